// ==== draw_engine_top.sv ====
// --------------------
// draw engine top
// sequencer, parallel outline lanes and framebuffer writer
// --------------------

module draw_engine_top #(
    parameter int DRAW_LANES = 4,
    parameter int SHAPE_CNT  = 15   // at most 15 so colours fit
) (
    input  logic             clk_100m,
    input  logic             rst_n,
    input  logic             start,
    input  geom_pkg::coord_t rd_x,
    input  geom_pkg::coord_t rd_y,
    output logic             busy,
    output logic             done,
    output fb_pkg::cidx_t    rd_cidx
);
    import geom_pkg::*;
    import fb_pkg::*;

    logic                  clear_start;
    logic                  clear_done;
    logic [DRAW_LANES-1:0] req;
    logic [DRAW_LANES-1:0] ack;
    logic [DRAW_LANES-1:0] lane_busy;
    logic [DRAW_LANES-1:0] oe;
    logic [DRAW_LANES-1:0] pix_valid;

    // shared command bus
    coord_t cmd_x0, cmd_y0, cmd_x1, cmd_y1;
    cidx_t  cmd_cidx;

    // per lane pixel outputs
    coord_t pix_x [DRAW_LANES];
    coord_t pix_y [DRAW_LANES];
    cidx_t  pix_cidx [DRAW_LANES];

    shape_sequencer #(
        .DRAW_LANES (DRAW_LANES),
        .SHAPE_CNT  (SHAPE_CNT)
    ) u_shape_sequencer (
        .clk_100m    (clk_100m),
        .rst_n       (rst_n),
        .start       (start),
        .clear_done  (clear_done),
        .ack         (ack),
        .lane_busy   (lane_busy),
        .clear_start (clear_start),
        .req         (req),
        .cmd_x0      (cmd_x0),
        .cmd_y0      (cmd_y0),
        .cmd_x1      (cmd_x1),
        .cmd_y1      (cmd_y1),
        .cmd_cidx    (cmd_cidx),
        .busy        (busy),
        .done        (done)
    );

    for (genvar i = 0; i < DRAW_LANES; i++) begin : g_lane
        draw_rectangle u_draw_rectangle (
            .clk_100m  (clk_100m),
            .rst_n     (rst_n),
            .req       (req[i]),
            .x0        (cmd_x0),
            .y0        (cmd_y0),
            .x1        (cmd_x1),
            .y1        (cmd_y1),
            .cidx_in   (cmd_cidx),
            .oe        (oe[i]),
            .ack       (ack[i]),
            .pix_x     (pix_x[i]),
            .pix_y     (pix_y[i]),
            .pix_cidx  (pix_cidx[i]),
            .pix_valid (pix_valid[i]),
            .busy      (lane_busy[i])
        );
    end

    fb_writer #(
        .DRAW_LANES (DRAW_LANES)
    ) u_fb_writer (
        .clk_100m    (clk_100m),
        .rst_n       (rst_n),
        .clear_start (clear_start),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_cidx    (pix_cidx),
        .pix_valid   (pix_valid),
        .rd_x        (rd_x),
        .rd_y        (rd_y),
        .oe          (oe),
        .clear_done  (clear_done),
        .rd_cidx     (rd_cidx)
    );

endmodule

// ==== draw_rectangle.sv ====
// --------------------
// rectangle outline lane
// walks the four edges, one pixel per granted cycle
// --------------------

module draw_rectangle (
    input  logic             clk_100m,
    input  logic             rst_n,
    input  logic             req,
    input  geom_pkg::coord_t x0,
    input  geom_pkg::coord_t y0,
    input  geom_pkg::coord_t x1,
    input  geom_pkg::coord_t y1,
    input  fb_pkg::cidx_t    cidx_in,
    input  logic             oe,
    output logic             ack,
    output geom_pkg::coord_t pix_x,
    output geom_pkg::coord_t pix_y,
    output fb_pkg::cidx_t    pix_cidx,
    output logic             pix_valid,
    output logic             busy
);
    import geom_pkg::*;
    import fb_pkg::*;

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_TOP    = 3'd1;  // x0 -> x1 along y0
    localparam logic [2:0] S_RIGHT  = 3'd2;  // y0+1 -> y1 along x1
    localparam logic [2:0] S_BOTTOM = 3'd3;  // x1-1 -> x0 along y1
    localparam logic [2:0] S_LEFT   = 3'd4;  // y1-1 -> y0+1 along x0

    localparam coord_t STEP = coord_t'(1);

    logic [2:0] state;
    coord_t     rx0, ry0, rx1, ry1;  // latched corners
    logic       latch;
    logic       step;                // current pixel written this edge

    assign latch     = (state == S_IDLE) && req && !ack;
    assign step      = pix_valid && oe;
    assign pix_valid = (state != S_IDLE);
    assign busy      = pix_valid;  // drops with the last granted pixel

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state <= S_IDLE;
            ack   <= 1'b0;
        end else begin
            if (latch) begin
                ack <= 1'b1;
            end else if (!req) begin
                ack <= 1'b0;
            end

            case (state)
                S_IDLE: if (latch) state <= S_TOP;
                S_TOP: if (step && pix_x == rx1) state <= S_RIGHT;
                S_RIGHT: if (step && pix_y == ry1) state <= S_BOTTOM;
                S_BOTTOM: if (step && pix_x == rx0) begin
                    // a two-row box has no left edge pixels left
                    state <= (ry1 - STEP == ry0) ? S_IDLE : S_LEFT;
                end
                S_LEFT: if (step && pix_y == ry0 + STEP) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // corners, colour and walking position
    always_ff @(posedge clk_100m) begin
        if (latch) begin
            rx0      <= x0;
            ry0      <= y0;
            rx1      <= x1;
            ry1      <= y1;
            pix_x    <= x0;
            pix_y    <= y0;
            pix_cidx <= cidx_in;
        end else if (step) begin
            case (state)
                S_TOP: begin
                    if (pix_x == rx1) pix_y <= pix_y + STEP;  // corner, turn down
                    else pix_x <= pix_x + STEP;
                end
                S_RIGHT: begin
                    if (pix_y == ry1) pix_x <= pix_x - STEP;
                    else pix_y <= pix_y + STEP;
                end
                S_BOTTOM: begin
                    if (pix_x == rx0) pix_y <= pix_y - STEP;
                    else pix_x <= pix_x - STEP;
                end
                S_LEFT: pix_y <= pix_y - STEP;
                default: pix_x <= pix_x;
            endcase
        end
    end

endmodule

// ==== fb_pkg.sv ====
// --------------------
// framebuffer package
// frame size, memory depth and colour index format
// --------------------

package fb_pkg;

    // image size in pixels
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;

    // one memory word per pixel, row major
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;  // 19200 words
    localparam int FB_ADDRW  = $clog2(FB_DEPTH);      // 15 bits

    // palette index stored per pixel
    localparam int CIDXW = 4;

    typedef logic [CIDXW-1:0] cidx_t;

endpackage

// ==== fb_writer.sv ====
// --------------------
// framebuffer writer
// clears memory, arbitrates lane pixels, serves reads
// --------------------

module fb_writer #(
    parameter int DRAW_LANES = 4
) (
    input  logic                  clk_100m,
    input  logic                  rst_n,
    input  logic                  clear_start,
    input  geom_pkg::coord_t      pix_x [DRAW_LANES],
    input  geom_pkg::coord_t      pix_y [DRAW_LANES],
    input  fb_pkg::cidx_t         pix_cidx [DRAW_LANES],
    input  logic [DRAW_LANES-1:0] pix_valid,
    input  geom_pkg::coord_t      rd_x,
    input  geom_pkg::coord_t      rd_y,
    output logic [DRAW_LANES-1:0] oe,
    output logic                  clear_done,
    output fb_pkg::cidx_t         rd_cidx
);
    import geom_pkg::*;
    import fb_pkg::*;

    localparam int LANE_W = (DRAW_LANES > 1) ? $clog2(DRAW_LANES) : 1;

    cidx_t mem [FB_DEPTH];  // one colour index per pixel

    logic                clearing;
    logic [FB_ADDRW-1:0] clr_addr;
    logic [LANE_W-1:0]   last_idx;   // lane granted most recently
    logic                grant;
    logic [LANE_W-1:0]   grant_idx;
    logic [FB_ADDRW-1:0] pix_addr;
    logic [FB_ADDRW-1:0] rd_addr;
    logic                we;
    logic [FB_ADDRW-1:0] waddr;
    cidx_t               wdata;

    assign clear_done = !clearing;

    // round robin, search starts one past the last winner
    always_comb begin
        int cand;
        oe        = '0;
        grant     = 1'b0;
        grant_idx = '0;
        for (int i = 1; i <= DRAW_LANES; i++) begin
            cand = (int'(last_idx) + i) % DRAW_LANES;
            if (!grant && !clearing && pix_valid[cand]) begin
                grant     = 1'b1;
                grant_idx = LANE_W'(cand);
            end
        end
        if (grant) oe[grant_idx] = 1'b1;
    end

    // row major address, x + y * width
    assign pix_addr = FB_ADDRW'(pix_y[grant_idx]) * FB_ADDRW'(FB_WIDTH) +
                      FB_ADDRW'(pix_x[grant_idx]);
    assign rd_addr  = FB_ADDRW'(rd_y) * FB_ADDRW'(FB_WIDTH) + FB_ADDRW'(rd_x);

    // clearing owns the write port
    always_comb begin
        we    = clearing || grant;
        waddr = clearing ? clr_addr : pix_addr;
        wdata = clearing ? cidx_t'(0) : pix_cidx[grant_idx];
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            clearing <= 1'b0;
            clr_addr <= '0;
            last_idx <= LANE_W'(DRAW_LANES - 1);  // lane 0 wins first
        end else begin
            if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == FB_ADDRW'(FB_DEPTH - 1)) clearing <= 1'b0;
            end else if (clear_start) begin
                clearing <= 1'b1;
                clr_addr <= '0;
            end
            if (grant) last_idx <= grant_idx;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (we) mem[waddr] <= wdata;
    end

    // separate read port, one cycle latency
    always_ff @(posedge clk_100m) begin
        rd_cidx <= mem[rd_addr];
    end

endmodule

// ==== geom_pkg.sv ====
// --------------------
// geometry package
// screen coordinates shared by the sequencer, lanes and writer
// --------------------

package geom_pkg;

    // wide enough for any framebuffer position, with sign for edge maths
    localparam int CORDW = 16;

    // one signed screen coordinate
    typedef logic signed [CORDW-1:0] coord_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the draw engine testbench with verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_draw_engine -f tb.f -o sim_draw_engine > build.log 2>&1 \
    && ./obj_dir/sim_draw_engine > sim.log 2>&1

grep -qx "Finished with no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== shape_sequencer.sv ====
// --------------------
// shape sequencer
// clears the frame, then hands nested rectangles to idle lanes
// --------------------

module shape_sequencer #(
    parameter int DRAW_LANES = 4,
    parameter int SHAPE_CNT  = 15
) (
    input  logic                  clk_100m,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  clear_done,
    input  logic [DRAW_LANES-1:0] ack,
    input  logic [DRAW_LANES-1:0] lane_busy,
    output logic                  clear_start,
    output logic [DRAW_LANES-1:0] req,
    output geom_pkg::coord_t      cmd_x0,
    output geom_pkg::coord_t      cmd_y0,
    output geom_pkg::coord_t      cmd_x1,
    output geom_pkg::coord_t      cmd_y1,
    output fb_pkg::cidx_t         cmd_cidx,
    output logic                  busy,
    output logic                  done
);
    import geom_pkg::*;
    import fb_pkg::*;

    localparam int LANE_W = (DRAW_LANES > 1) ? $clog2(DRAW_LANES) : 1;
    localparam int KW     = $clog2(SHAPE_CNT + 1);

    // outer ring corners, each shape moves one pixel inward
    localparam coord_t RECT_X0 = coord_t'(40);
    localparam coord_t RECT_Y0 = coord_t'(30);
    localparam coord_t RECT_X1 = coord_t'(120);
    localparam coord_t RECT_Y1 = coord_t'(90);

    localparam logic [2:0] S_IDLE       = 3'd0;
    localparam logic [2:0] S_CLEAR      = 3'd1;
    localparam logic [2:0] S_WAIT_CLR   = 3'd2;
    localparam logic [2:0] S_DISPATCH   = 3'd3;
    localparam logic [2:0] S_WAIT_LANES = 3'd4;

    logic [2:0]        state;
    logic [KW-1:0]     shape_k;    // next shape to hand out
    coord_t            shape_off;
    logic              lane_free;
    logic [LANE_W-1:0] free_idx;
    logic              issue;      // put a new command on the bus

    assign shape_off = coord_t'(shape_k);

    // lowest numbered lane with busy and ack both low
    always_comb begin
        lane_free = 1'b0;
        free_idx  = '0;
        for (int i = DRAW_LANES - 1; i >= 0; i--) begin
            if (!lane_busy[i] && !ack[i]) begin
                lane_free = 1'b1;
                free_idx  = LANE_W'(i);
            end
        end
    end

    assign issue = (state == S_DISPATCH) && (req == '0) &&
                   (shape_k != KW'(SHAPE_CNT)) && lane_free;

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            shape_k     <= '0;
            req         <= '0;
            clear_start <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
        end else begin
            clear_start <= 1'b0;
            done        <= 1'b0;
            case (state)
                S_IDLE: if (start) begin
                    busy        <= 1'b1;
                    clear_start <= 1'b1;
                    shape_k     <= '0;
                    state       <= S_CLEAR;
                end
                S_CLEAR: state <= S_WAIT_CLR;  // writer picks up clear_start here
                S_WAIT_CLR: if (clear_done) state <= S_DISPATCH;
                S_DISPATCH: begin
                    if (req != '0) begin
                        // lane has latched, release it
                        if ((req & ack) != '0) begin
                            req     <= '0;
                            shape_k <= shape_k + 1'b1;
                        end
                    end else if (shape_k == KW'(SHAPE_CNT)) begin
                        state <= S_WAIT_LANES;
                    end else if (issue) begin
                        req[free_idx] <= 1'b1;
                    end
                end
                S_WAIT_LANES: if (lane_busy == '0 && ack == '0) begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // command bus, frozen while any req is high
    always_ff @(posedge clk_100m) begin
        if (issue) begin
            cmd_x0   <= RECT_X0 + shape_off;
            cmd_y0   <= RECT_Y0 + shape_off;
            cmd_x1   <= RECT_X1 - shape_off;
            cmd_y1   <= RECT_Y1 - shape_off;
            cmd_cidx <= cidx_t'(shape_k + 1'b1);  // index 0 is background
        end
    end

endmodule

// ==== tb.f ====
geom_pkg.sv
fb_pkg.sv
shape_sequencer.sv
draw_rectangle.sv
fb_writer.sv
draw_engine_top.sv
tb_clock_gen.sv
tb_draw_engine.sv

// ==== tb_clock_gen.sv ====
// --------------------
// testbench clock and reset
// 100 MHz clock, reset held low for a fixed number of cycles
// --------------------

module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_100m,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;  // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_100m);
        rst_n <= 1'b1;
    end

endmodule

// ==== tb_draw_engine.sv ====
// --------------------
// draw engine testbench
// two drawing runs with a randomised image readback after each
// --------------------

module tb_draw_engine;
    timeunit 1ns;
    timeprecision 1ps;

    import geom_pkg::*;
    import fb_pkg::*;

    localparam int DRAW_LANES  = 4;
    localparam int SHAPE_CNT   = 15;
    localparam int CYCLE_LIMIT = 120000;  // two runs plus sweeps with margin
    localparam logic [31:0] LFSR_SEED = 32'he63c_8a59;
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    // outer ring of the nested outlines
    localparam int RING_X0 = 40;
    localparam int RING_Y0 = 30;
    localparam int RING_X1 = 120;
    localparam int RING_Y1 = 90;

    logic   clk_100m;
    logic   rst_n;
    logic   start = 1'b0;
    coord_t rd_x  = '0;
    coord_t rd_y  = '0;
    logic   busy;
    logic   done;
    cidx_t  rd_cidx;

    logic [31:0] lfsr_state = LFSR_SEED;
    string       test_name  = "reset";
    int          order [FB_DEPTH];  // pixel read order
    int          cycle_count   = 0;
    int          checked_count = 0;
    int          done_count    = 0;
    logic        run_open      = 1'b0;  // start accepted and done not yet seen

    // readback pipeline with data one cycle after the address
    logic   chk_valid = 1'b0;
    cidx_t  chk_exp   = '0;
    logic   valid_d   = 1'b0;
    cidx_t  exp_d     = '0;
    coord_t px_d      = '0;
    coord_t py_d      = '0;

    tb_clock_gen #(
        .RESET_CYCLES (10)
    ) u_tb_clock_gen (
        .clk_100m (clk_100m),
        .rst_n    (rst_n)
    );

    draw_engine_top #(
        .DRAW_LANES (DRAW_LANES),
        .SHAPE_CNT  (SHAPE_CNT)
    ) u_draw_engine_top (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .start    (start),
        .rd_x     (rd_x),
        .rd_y     (rd_y),
        .busy     (busy),
        .done     (done),
        .rd_cidx  (rd_cidx)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] nxt;
        nxt = s >> 1;
        if (s[0]) nxt = nxt ^ LFSR_POLY;
        return nxt;
    endfunction

    // one lfsr step per bit
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
        return value;
    endfunction

    // ring depth from the nearest outer edge gives the colour
    function automatic cidx_t expected_pixel(input int x, input int y);
        int d;
        d = x - RING_X0;
        if (y - RING_Y0 < d) d = y - RING_Y0;
        if (RING_X1 - x < d) d = RING_X1 - x;
        if (RING_Y1 - y < d) d = RING_Y1 - y;
        if (d >= 0 && d < SHAPE_CNT) return cidx_t'(d + 1);
        return cidx_t'(0);
    endfunction

    task automatic shuffle_order();
        int j;
        int tmp;
        for (int i = 0; i < FB_DEPTH; i++) order[i] = i;
        for (int i = FB_DEPTH - 1; i > 0; i--) begin  // fisher-yates
            j        = random_bits(15) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
    endtask

    task automatic idle_gap(input int max_bits);
        repeat (random_bits(max_bits) + 1) @(posedge clk_100m);
    endtask

    task automatic pulse_start();
        @(posedge clk_100m);
        start <= 1'b1;
        @(posedge clk_100m);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        do @(posedge clk_100m); while (!done);
    endtask

    task automatic sweep_image(input string name);
        int x;
        int y;
        test_name = name;
        shuffle_order();
        for (int i = 0; i < FB_DEPTH; i++) begin
            x = order[i] % FB_WIDTH;
            y = order[i] / FB_WIDTH;
            @(posedge clk_100m);
            rd_x      <= coord_t'(x);
            rd_y      <= coord_t'(y);
            chk_valid <= 1'b1;
            chk_exp   <= expected_pixel(x, y);
        end
        @(posedge clk_100m);
        chk_valid <= 1'b0;
        repeat (3) @(posedge clk_100m);  // let the last compare land
    endtask

    always @(posedge clk_100m) begin
        valid_d <= chk_valid;
        exp_d   <= chk_exp;
        px_d    <= rd_x;
        py_d    <= rd_y;
        if (valid_d) checked_count <= checked_count + 1;
        if (!rst_n) run_open <= 1'b0;
        else if (start && !busy) run_open <= 1'b1;
        else if (done) run_open <= 1'b0;
        if (rst_n && done) done_count <= done_count + 1;
    end

    // watchdog
    always @(posedge clk_100m) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure($sformatf("timeout after %0d cycles, run did not finish",
                                     cycle_count));
        end
    end

    a_reset_idle: assert property (@(posedge clk_100m) !rst_n |=> (!busy && !done))
        else report_failure($sformatf("mismatch %s reset_idle expected=0/0 actual=%0b/%0b",
                                      test_name, $sampled(busy), $sampled(done)));

    a_start_busy: assert property (@(posedge clk_100m) disable iff (!rst_n)
                                   (start && !busy) |=> busy)
        else report_failure($sformatf("mismatch %s start_busy expected=1 actual=0",
                                      test_name));

    a_done_pulse: assert property (@(posedge clk_100m) disable iff (!rst_n)
                                   done |=> !done)
        else report_failure($sformatf("mismatch %s done_pulse expected=0 actual=1",
                                      test_name));

    a_done_idle: assert property (@(posedge clk_100m) disable iff (!rst_n)
                                  done |-> !busy)
        else report_failure($sformatf("mismatch %s done_idle expected=0 actual=1",
                                      test_name));

    // a start while busy must not produce a second done
    a_done_run: assert property (@(posedge clk_100m) disable iff (!rst_n)
                                 done |-> run_open)
        else report_failure($sformatf("mismatch %s done_once expected=0 actual=1",
                                      test_name));

    a_busy_end: assert property (@(posedge clk_100m) disable iff (!rst_n)
                                 $fell(busy) |-> done)
        else report_failure($sformatf("mismatch %s busy_end expected=1 actual=0",
                                      test_name));

    a_pixel: assert property (@(posedge clk_100m) disable iff (!rst_n)
                              valid_d |-> (rd_cidx == exp_d))
        else report_failure($sformatf("mismatch %s expected=%0d actual=%0d at x=%0d y=%0d",
                                      test_name, $sampled(exp_d), $sampled(rd_cidx),
                                      $sampled(px_d), $sampled(py_d)));

    initial begin
        while (rst_n !== 1'b1) @(posedge clk_100m);

        // first run with a stray start while busy
        test_name = "run1";
        idle_gap(4);
        pulse_start();
        while (!busy) @(posedge clk_100m);
        idle_gap(3);
        pulse_start();
        wait_done();
        sweep_image("run1_image");

        test_name = "run2";
        idle_gap(4);
        pulse_start();
        wait_done();
        sweep_image("run2_image");

        if (checked_count == 2 * FB_DEPTH && done_count == 2) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_failure($sformatf("incomplete run, %0d pixels checked and %0d done pulses",
                                     checked_count, done_count));
        end
    end

endmodule
